// File: Bender.yml
package:
  name: iccm_mem

sources:
  - common/iccm_pkg.sv
  - hdl/iccm_sram.sv
  - hdl/iccm_bank_array.sv
  - redundancy/iccm_red_rows.sv
  - hdl/iccm_rd_path.sv
  - hdl/iccm_mem.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/iccm_properties.sv
      - verification/iccm_tb.sv

// File: common/iccm_pkg.sv
// ICCM shared package with geometry constants, vector types, request struct and address step
package iccm_pkg;

   //*******************************************************************
   // Geometry
   //*******************************************************************
   localparam int ICCM_BITS     = 10;      // Byte address width
   localparam int NUM_BANKS     = 4;
   localparam int BANK_HI       = 3;       // Top bank select bit
   localparam int BANK_INDEX_LO = 4;       // Lowest row index bit
   localparam int INDEX_BITS    = 6;
   localparam int WORD_W        = 39;      // Payload plus check bits
   localparam int PAYLOAD_W     = 32;

   localparam logic [2:0] SIZE_DW = 3'd3;  // Double-word access code

   //*******************************************************************
   // Types
   //*******************************************************************
   typedef logic [ICCM_BITS-1:1]  iccm_addr_t;   // Halfword address
   typedef logic [ICCM_BITS-1:2]  word_addr_t;   // Word address
   typedef logic [BANK_HI-2:0]    bank_sel_t;
   typedef logic [INDEX_BITS-1:0] row_idx_t;
   typedef logic [WORD_W-1:0]     iccm_word_t;
   typedef logic [2*WORD_W-1:0]   iccm_pair_t;

   // One access request, sampled every cycle
   typedef struct packed {
      logic       wren;
      logic       rden;
      iccm_addr_t addr;
      logic [2:0] size;
      iccm_pair_t wdata;                 // High word in the upper half
   } iccm_req_t;

   //*******************************************************************
   // Address of the second word of an access
   //*******************************************************************
   // Steps one word for a double-word access, else one halfword
   function automatic iccm_addr_t next_addr(iccm_addr_t addr, logic [2:0] size);
      iccm_addr_t incr;
      incr = (size == SIZE_DW) ? iccm_addr_t'(2) : iccm_addr_t'(1);
      return addr + incr;
   endfunction

endpackage

// File: hdl/iccm_bank_array.sv
// ICCM bank array steering enables, row indices and write data into four SRAM banks
`timescale 1ns/1ps

module iccm_bank_array import iccm_pkg::*; (
   input  logic                       clk,
   input  iccm_req_t                  req,
   output iccm_word_t [NUM_BANKS-1:0] bank_dout     // Registered SRAM words
);

   iccm_addr_t addr_inc;                           // Address of the second word
   bank_sel_t  bank_lo;
   bank_sel_t  bank_hi;
   row_idx_t   row_lo;
   row_idx_t   row_hi;

   assign addr_inc = next_addr(req.addr, req.size);

   assign bank_lo = req.addr[BANK_HI:2];
   assign bank_hi = addr_inc[BANK_HI:2];
   assign row_lo  = req.addr[ICCM_BITS-1:BANK_INDEX_LO];
   assign row_hi  = addr_inc[ICCM_BITS-1:BANK_INDEX_LO];

   //*******************************************************************
   // Per-bank control and storage
   //*******************************************************************
   for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
      logic       hit_lo;
      logic       hit_hi;
      logic       en;
      logic       we;
      row_idx_t   row;
      iccm_word_t wdata;

      assign hit_lo = (bank_lo == bank_sel_t'(i));
      assign hit_hi = (bank_hi == bank_sel_t'(i));

      assign en = (req.wren | req.rden) & (hit_lo | hit_hi);
      assign we = req.wren & (hit_lo | hit_hi);

      // Writes keep the request row even when the pair wraps into the next row
      always_comb begin
         if (req.wren) begin
            row = row_lo;
         end else if (hit_hi) begin
            row = row_hi;
         end else begin
            row = row_lo;
         end
      end

      // Even banks low half, odd banks high half
      assign wdata = req.wdata[(i % 2)*WORD_W +: WORD_W];

      iccm_sram u_sram (
         .clk   (clk),
         .en    (en),
         .we    (we),
         .row   (row),
         .wdata (wdata),
         .rdata (bank_dout[i])
      );
   end

endmodule

// File: hdl/iccm_mem.sv
// ICCM top level joining the word banks, the redundancy rows and the read path
`timescale 1ns/1ps

module iccm_mem import iccm_pkg::*; (
   input  logic                   clk,
   input  logic                   arst_n,
   input  iccm_req_t              req,               // Write or read request
   input  logic                   buf_correct_ecc,   // Correction write strobe
   input  logic                   correction_state,  // Correction sequence in progress
   output logic [2*PAYLOAD_W-1:0] rd_data,
   output iccm_pair_t             rd_data_ecc
);

   iccm_word_t [NUM_BANKS-1:0] bank_dout;
   logic       [NUM_BANKS-1:0] red_sel0_q;
   logic       [NUM_BANKS-1:0] red_sel1_q;
   iccm_word_t                 red_data0;
   iccm_word_t                 red_data1;

   //*******************************************************************
   // Storage
   //*******************************************************************
   iccm_bank_array u_bank_array (
      .clk       (clk),
      .req       (req),
      .bank_dout (bank_dout)
   );

   // Spare rows for words with persistent faults
   iccm_red_rows u_red_rows (
      .clk              (clk),
      .arst_n           (arst_n),
      .req              (req),
      .buf_correct_ecc  (buf_correct_ecc),
      .correction_state (correction_state),
      .red_sel0_q       (red_sel0_q),
      .red_sel1_q       (red_sel1_q),
      .red_data0        (red_data0),
      .red_data1        (red_data1)
   );

   //*******************************************************************
   // Read data
   //*******************************************************************
   iccm_rd_path u_rd_path (
      .clk         (clk),
      .arst_n      (arst_n),
      .req         (req),
      .bank_dout   (bank_dout),
      .red_sel0_q  (red_sel0_q),
      .red_sel1_q  (red_sel1_q),
      .red_data0   (red_data0),
      .red_data1   (red_data1),
      .rd_data     (rd_data),
      .rd_data_ecc (rd_data_ecc)
   );

endmodule

// File: hdl/iccm_rd_path.sv
// ICCM read path with bank pointers, redundant row substitution and halfword alignment
`timescale 1ns/1ps

module iccm_rd_path import iccm_pkg::*; (
   input  logic                       clk,
   input  logic                       arst_n,
   input  iccm_req_t                  req,
   input  iccm_word_t [NUM_BANKS-1:0] bank_dout,
   input  logic       [NUM_BANKS-1:0] red_sel0_q,   // Row 0 replaces this bank
   input  logic       [NUM_BANKS-1:0] red_sel1_q,   // Row 1 replaces this bank
   input  iccm_word_t                 red_data0,
   input  iccm_word_t                 red_data1,
   output logic [2*PAYLOAD_W-1:0]     rd_data,
   output iccm_pair_t                 rd_data_ecc
);

   iccm_addr_t                 addr_inc;
   bank_sel_t                  lo_bank_q;
   logic                       lo_half_q;           // Address bit 1 of the read
   bank_sel_t                  hi_bank_q;
   iccm_word_t [NUM_BANKS-1:0] word_fn;
   iccm_word_t                 lo_word;
   iccm_word_t                 hi_word;
   logic [2*PAYLOAD_W-1:0]     rd_pre;

   assign addr_inc = next_addr(req.addr, req.size);

   //*******************************************************************
   // Pointers aligned with the SRAM output
   //*******************************************************************
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         lo_bank_q <= '0;
         lo_half_q <= 1'b0;
         hi_bank_q <= '0;
      end else begin
         lo_bank_q <= req.addr[BANK_HI:2];
         lo_half_q <= req.addr[1];
         hi_bank_q <= addr_inc[BANK_HI:2];
      end
   end

   // Row 1 wins over row 0
   always_comb begin
      for (int b = 0; b < NUM_BANKS; b++) begin
         if (red_sel1_q[b]) begin
            word_fn[b] = red_data1;
         end else if (red_sel0_q[b]) begin
            word_fn[b] = red_data0;
         end else begin
            word_fn[b] = bank_dout[b];
         end
      end
   end

   //*******************************************************************
   // Output assembly
   //*******************************************************************
   assign lo_word = word_fn[lo_bank_q];
   assign hi_word = word_fn[hi_bank_q];

   assign rd_data_ecc = {hi_word, lo_word};
   assign rd_pre      = {hi_word[PAYLOAD_W-1:0], lo_word[PAYLOAD_W-1:0]};

   // Odd halfword start drops the low halfword, zero fill on top
   assign rd_data = lo_half_q ? (rd_pre >> (PAYLOAD_W/2)) : rd_pre;

endmodule

// File: hdl/iccm_sram.sv
// ICCM word bank as a behavioral single-port SRAM with registered read data
`timescale 1ns/1ps

module iccm_sram import iccm_pkg::*; (
   input  logic       clk,
   input  logic       en,          // Bank select
   input  logic       we,          // Write when selected
   input  row_idx_t   row,
   input  iccm_word_t wdata,
   output iccm_word_t rdata
);

   iccm_word_t mem [2**INDEX_BITS];

   //*******************************************************************
   // Array access
   //*******************************************************************
   always_ff @(posedge clk) begin
      if (en) begin
         if (we) begin
            mem[row] <= wdata;
         end else begin
            rdata <= mem[row];     // Holds until the next read
         end
      end
   end

endmodule

// File: project.f
+incdir+verification
common/iccm_pkg.sv
hdl/iccm_sram.sv
hdl/iccm_bank_array.sv
redundancy/iccm_red_rows.sv
hdl/iccm_rd_path.sv
hdl/iccm_mem.sv
verification/iccm_properties.sv
verification/iccm_tb.sv

// File: redundancy/iccm_red_rows.sv
// ICCM redundancy store of two spare rows with address match, data update and LRU replacement
`timescale 1ns/1ps

module iccm_red_rows import iccm_pkg::*; (
   input  logic                 clk,
   input  logic                 arst_n,
   input  iccm_req_t            req,
   input  logic                 buf_correct_ecc,   // Load a row with the request word
   input  logic                 correction_state,
   output logic [NUM_BANKS-1:0] red_sel0_q,
   output logic [NUM_BANKS-1:0] red_sel1_q,
   output iccm_word_t           red_data0,
   output iccm_word_t           red_data1
);

   iccm_addr_t                 addr_inc;
   logic                       is_dw;
   word_addr_t [1:0]           row_addr;
   logic       [1:0]           row_valid;
   iccm_word_t [1:0]           row_data;
   logic                       row_lru;           // Row to replace next
   logic       [1:0]           load_en;
   logic       [1:0]           data_en;
   logic       [1:0]           take_hi;
   logic       [1:0]           hit_lo;
   logic       [1:0]           hit_hi;
   iccm_word_t [1:0]           data_in;
   logic [1:0][NUM_BANKS-1:0]  sel;
   logic                       lru_en;
   logic                       lru_in;

   assign addr_inc = next_addr(req.addr, req.size);
   assign is_dw    = (req.size == SIZE_DW);

   //*******************************************************************
   // Row match and update control
   //*******************************************************************
   always_comb begin
      for (int r = 0; r < 2; r++) begin
         load_en[r] = buf_correct_ecc & (row_lru == 1'(r));

         hit_lo[r] = (req.addr[ICCM_BITS-1:2] == row_addr[r]);
         hit_hi[r] = (addr_inc[ICCM_BITS-1:2] == row_addr[r]);

         // Word writes match down to bit 2, double words down to bit 3
         data_en[r] = load_en[r] |
                      (row_valid[r] & req.wren &
                       (req.addr[ICCM_BITS-1:3] == row_addr[r][ICCM_BITS-1:3]) &
                       ((req.addr[2] == row_addr[r][2]) | is_dw));

         // Correction data sits in both halves, so the low half is as good
         take_hi[r] = ((req.addr[2] == row_addr[r][2]) & req.addr[2]) |
                      (row_addr[r][2] & is_dw);
         data_in[r] = take_hi[r] ? req.wdata[2*WORD_W-1:WORD_W] : req.wdata[WORD_W-1:0];

         for (int b = 0; b < NUM_BANKS; b++) begin
            sel[r][b] = row_valid[r] &
                        ((hit_lo[r] & (req.addr[BANK_HI:2] == bank_sel_t'(b))) |
                         (hit_hi[r] & (addr_inc[BANK_HI:2] == bank_sel_t'(b))));
         end
      end
   end

   // A hit during correction marks the other row for replacement
   assign lru_en = buf_correct_ecc |
                   (((|sel[0]) | (|sel[1])) & req.rden & correction_state);
   assign lru_in = buf_correct_ecc ? ~row_lru : (|sel[0]);

   //*******************************************************************
   // Control registers
   //*******************************************************************
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         row_valid  <= '0;
         row_lru    <= 1'b0;
         red_sel0_q <= '0;
         red_sel1_q <= '0;
      end else begin
         for (int r = 0; r < 2; r++) begin
            if (load_en[r]) begin
               row_valid[r] <= 1'b1;     // Sticky until reset
            end
         end
         if (lru_en) begin
            row_lru <= lru_in;
         end
         red_sel0_q <= sel[0];           // Lines up with SRAM read data
         red_sel1_q <= sel[1];
      end
   end

   //*******************************************************************
   // Row address and data
   //*******************************************************************
   always_ff @(posedge clk) begin
      for (int r = 0; r < 2; r++) begin
         if (load_en[r]) begin
            row_addr[r] <= req.addr[ICCM_BITS-1:2];
         end
         if (data_en[r]) begin
            row_data[r] <= data_in[r];
         end
      end
   end

   assign red_data0 = row_data[0];
   assign red_data1 = row_data[1];

endmodule

// File: verification/iccm_properties.sv
// ICCM redundancy row checks on valid loading, valid retention and LRU toggling
`timescale 1ns/1ps

module iccm_properties (
   input logic       clk,
   input logic       arst_n,
   input logic       buf_correct_ecc,
   input logic [1:0] row_valid,
   input logic       row_lru
);

   int assert_fails;                      // Failure count

   initial assert_fails = 0;

   //*******************************************************************
   // Row valids
   //*******************************************************************
   for (genvar r = 0; r < 2; r++) begin : g_row
      valid_on_load: assert property (@(posedge clk) disable iff (!arst_n)
         (buf_correct_ecc && (row_lru == 1'(r))) |=> row_valid[r])
      else begin
         $error("spare row %0d not valid after its correction", r);
         assert_fails++;
      end

      // Only reset clears a row
      valid_sticky: assert property (@(posedge clk) disable iff (!arst_n)
         row_valid[r] |=> row_valid[r])
      else begin
         $error("spare row %0d lost its valid without reset", r);
         assert_fails++;
      end
   end

   lru_flips: assert property (@(posedge clk) disable iff (!arst_n)
      buf_correct_ecc |=> (row_lru != $past(row_lru)))
   else begin
      $error("LRU did not invert on a correction");
      assert_fails++;
   end

endmodule

// File: verification/iccm_ref_model.svh
// ICCM reference model of the word memory and the two spare rows with LRU replacement
`ifndef ICCM_REF_MODEL_SVH
`define ICCM_REF_MODEL_SVH

iccm_word_t ref_mem [2**(ICCM_BITS-2)];
word_addr_t spare_addr [2];
logic       spare_valid [2];
iccm_word_t spare_data [2];
logic       spare_lru;                     // Row the next correction replaces

// Second word sits 4 bytes on for double words, else 2 bytes on
function automatic iccm_addr_t second_half(iccm_addr_t a, logic [2:0] size);
   if (size == SIZE_DW) begin
      return a + 9'd2;
   end
   return a + 9'd1;
endfunction

function automatic void clear_spares();
   spare_valid[0] = 1'b0;
   spare_valid[1] = 1'b0;
   spare_lru      = 1'b0;
endfunction

// Odd banks hold the high half of a pair
function automatic iccm_word_t half_for(word_addr_t w, iccm_pair_t d);
   return w[2] ? d[2*WORD_W-1:WORD_W] : d[WORD_W-1:0];
endfunction

function automatic void store_write(word_addr_t w0, word_addr_t w1, iccm_pair_t d);
   ref_mem[w0] = half_for(w0, d);
   ref_mem[w1] = half_for(w1, d);
   for (int r = 0; r < 2; r++) begin
      if (spare_valid[r] && (spare_addr[r] == w0 || spare_addr[r] == w1)) begin
         spare_data[r] = half_for(spare_addr[r], d);   // Row follows the memory
      end
   end
endfunction

function automatic void load_spare_row(word_addr_t w, iccm_word_t d);
   spare_addr[spare_lru]  = w;
   spare_valid[spare_lru] = 1'b1;
   spare_data[spare_lru]  = d;
   spare_lru              = ~spare_lru;
endfunction

// Row 1 wins when both rows hold the word
function automatic iccm_word_t word_seen(word_addr_t w);
   if (spare_valid[1] && spare_addr[1] == w) begin
      return spare_data[1];
   end else if (spare_valid[0] && spare_addr[0] == w) begin
      return spare_data[0];
   end
   return ref_mem[w];
endfunction

// Read hit while a correction is in progress
function automatic void note_read(word_addr_t w0, word_addr_t w1);
   logic hit0;
   logic hit1;
   hit0 = spare_valid[0] && (spare_addr[0] == w0 || spare_addr[0] == w1);
   hit1 = spare_valid[1] && (spare_addr[1] == w0 || spare_addr[1] == w1);
   if (hit0 || hit1) begin
      spare_lru = hit0;
   end
endfunction

`endif

// File: verification/iccm_tb.sv
// ICCM testbench with random stimulus, a reference model and per-test reporting
`timescale 1ns/1ps

module iccm_tb import iccm_pkg::*; ();

   localparam int TIMEOUT_CYCLES = 5000;  // Tests take about 1,200 cycles
   localparam int FILL_PAIRS     = 128;
   localparam int WORD_WRITES    = 300;
   localparam int HALF_READS     = 600;

   logic                   clk;
   logic                   arst_n;
   iccm_req_t              req;
   logic                   buf_correct_ecc;
   logic                   correction_state;
   logic [2*PAYLOAD_W-1:0] rd_data;
   iccm_pair_t             rd_data_ecc;

   integer                 seed;
   int                     cycles;
   int                     checks;
   int                     errors;
   int                     test_checks;
   int                     test_errors;
   int                     prop_fails;
   logic                   read_pending;
   iccm_pair_t             exp_ecc;
   logic [2*PAYLOAD_W-1:0] exp_data;
   word_addr_t             spot [5];       // Words used by the redundancy tests

   `include "iccm_ref_model.svh"

   iccm_mem DUT (
      .clk              (clk),
      .arst_n           (arst_n),
      .req              (req),
      .buf_correct_ecc  (buf_correct_ecc),
      .correction_state (correction_state),
      .rd_data          (rd_data),
      .rd_data_ecc      (rd_data_ecc)
   );

   bind iccm_red_rows iccm_properties u_props (
      .clk             (clk),
      .arst_n          (arst_n),
      .buf_correct_ecc (buf_correct_ecc),
      .row_valid       (row_valid),
      .row_lru         (row_lru)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   initial begin
      cycles = 0;
      while (cycles < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: the tests did not finish within %0d clock cycles", cycles);
      $display("*** FAILED ***");
      $finish;
   end

   //*******************************************************************
   // Stimulus and checking
   //*******************************************************************
   function automatic iccm_word_t rand_word();
      return iccm_word_t'({$random(seed), $random(seed)});
   endfunction

   function automatic logic [2*PAYLOAD_W-1:0] aligned_payload(logic odd, iccm_pair_t p);
      logic [2*PAYLOAD_W-1:0] pl;
      pl = {p[WORD_W +: PAYLOAD_W], p[PAYLOAD_W-1:0]};
      return odd ? (pl >> 16) : pl;     // Zero fill on top
   endfunction

   task automatic compare_read();
      if (read_pending) begin
         checks += 2;
         assert (rd_data_ecc === exp_ecc) else begin
            $display("error at %0d ns: rd_data_ecc expected %h, actual %h",
                     $time, exp_ecc, rd_data_ecc);
            errors++;
         end
         assert (rd_data === exp_data) else begin
            $display("error at %0d ns: rd_data expected %h, actual %h",
                     $time, exp_data, rd_data);
            errors++;
         end
      end
      read_pending = 1'b0;
   endtask

   // One request per clock, last read checked first
   task automatic drive_cycle(input iccm_req_t r, input logic corr, input logic cstate);
      iccm_addr_t a2;
      @(posedge clk);
      #2;
      compare_read();
      req              = r;
      buf_correct_ecc  = corr;
      correction_state = cstate;
      a2 = second_half(r.addr, r.size);
      if (corr) begin
         load_spare_row(r.addr[ICCM_BITS-1:2], r.wdata[WORD_W-1:0]);
      end
      if (r.wren) begin
         store_write(r.addr[ICCM_BITS-1:2], a2[ICCM_BITS-1:2], r.wdata);
      end
      if (r.rden) begin
         exp_ecc      = {word_seen(a2[ICCM_BITS-1:2]), word_seen(r.addr[ICCM_BITS-1:2])};
         exp_data     = aligned_payload(r.addr[1], exp_ecc);
         read_pending = 1'b1;
         if (cstate) begin
            note_read(r.addr[ICCM_BITS-1:2], a2[ICCM_BITS-1:2]);
         end
      end
   endtask

   function automatic iccm_req_t make_req(logic wr, iccm_addr_t a, logic [2:0] sz,
                                          iccm_pair_t d);
      iccm_req_t r;
      r       = '0;
      r.wren  = wr;
      r.rden  = ~wr;
      r.addr  = a;
      r.size  = sz;
      r.wdata = d;
      return r;
   endfunction

   task automatic read_at(input iccm_addr_t a, input logic [2:0] sz);
      drive_cycle(make_req(1'b0, a, sz, '0), 1'b0, 1'b0);
   endtask

   task automatic write_word(input word_addr_t w, input iccm_word_t d);
      drive_cycle(make_req(1'b1, {w, 1'b0}, 3'd2, {d, d}), 1'b0, 1'b0);
   endtask

   task automatic write_pair(input word_addr_t w, input iccm_pair_t d);
      drive_cycle(make_req(1'b1, {w[ICCM_BITS-1:3], 2'b00}, SIZE_DW, d), 1'b0, 1'b0);
   endtask

   task automatic correct_word(input word_addr_t w, input iccm_word_t d);
      iccm_req_t r;
      r      = make_req(1'b0, {w, 1'b0}, 3'd2, {d, d});
      r.rden = 1'b0;                    // Strobe only, no access
      drive_cycle(r, 1'b1, 1'b1);
   endtask

   task automatic idle();
      drive_cycle('0, 1'b0, 1'b0);
   endtask

   // Both halfwords, the pair from the word below and the aligned double word
   task automatic check_around(input word_addr_t w);
      word_addr_t below;
      below = w - 8'd1;
      read_at({w, 1'b0}, 3'd2);
      read_at({w, 1'b1}, 3'd1);
      read_at({below, 1'b1}, 3'd0);
      read_at({w[ICCM_BITS-1:3], 2'b00}, SIZE_DW);
   endtask

   task automatic reset_midrun();
      idle();
      @(posedge clk);
      #2;
      arst_n = 1'b0;
      clear_spares();
      repeat (3) @(posedge clk);
      #2;
      arst_n = 1'b1;
   endtask

   task automatic begin_test();
      test_checks = checks;
      test_errors = errors;
   endtask

   task automatic close_test(input string name);
      idle();
      $display("Test %s: %0d checks, %0d errors", name, checks - test_checks,
               errors - test_errors);
   endtask

   //*******************************************************************
   // Test sequence
   //*******************************************************************
   initial begin
      seed             = 32'h2be5;
      checks           = 0;
      errors           = 0;
      read_pending     = 1'b0;
      arst_n           = 1'b0;
      req              = '0;
      buf_correct_ecc  = 1'b0;
      correction_state = 1'b0;
      clear_spares();
      repeat (10) @(posedge clk);
      #2;
      arst_n = 1'b1;

      begin_test();
      for (int i = 0; i < FILL_PAIRS; i++) begin
         write_pair(word_addr_t'(2*i), {rand_word(), rand_word()});
      end
      for (int i = 0; i < FILL_PAIRS; i++) begin
         read_at(iccm_addr_t'(4*i), SIZE_DW);
      end
      close_test("1 double-word fill");

      begin_test();
      for (int i = 0; i < WORD_WRITES; i++) begin
         write_word(word_addr_t'($random(seed)), rand_word());
      end
      for (int i = 0; i < HALF_READS; i++) begin
         read_at(iccm_addr_t'($random(seed)), 3'(i % 3));
      end
      close_test("2 halfword reads");

      begin_test();
      spot[0] = word_addr_t'($random(seed));
      for (int i = 1; i < 5; i++) begin
         spot[i] = spot[0] + word_addr_t'(37*i);   // Far apart, no shared pairs
      end
      correct_word(spot[0], rand_word());           // Row 0
      correct_word(spot[1], rand_word());           // Row 1
      check_around(spot[0]);
      check_around(spot[1]);
      close_test("3 correction substitution");

      begin_test();
      write_word(spot[0], rand_word());
      check_around(spot[0]);
      write_pair(spot[1], {rand_word(), rand_word()});
      write_pair(spot[0], {rand_word(), rand_word()});
      check_around(spot[1]);
      check_around(spot[0]);
      close_test("4 write through corrected rows");

      begin_test();
      correct_word(spot[2], rand_word());
      correct_word(spot[3], rand_word());
      // Hit on row 0 during correction points the LRU at row 1
      drive_cycle(make_req(1'b0, {spot[2], 1'b0}, 3'd2, '0), 1'b0, 1'b1);
      correct_word(spot[4], rand_word());
      check_around(spot[3]);
      check_around(spot[2]);
      check_around(spot[4]);
      close_test("5 LRU replacement");

      begin_test();
      reset_midrun();
      check_around(spot[2]);
      check_around(spot[4]);
      check_around(spot[0]);
      close_test("6 reset clears rows");

      prop_fails = DUT.u_red_rows.u_props.assert_fails;
      $display("Summary: %0d checks, %0d errors, %0d assertion failures",
               checks, errors, prop_fails);
      if (errors == 0 && prop_fails == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule
